/* include/core_defines.svh */
// Core sizing for a 32-bit RV32I datapath only; the ISA types in rv_isa_pkg assume these values
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////

// Data and address width
`define CORE_XLEN 32

// Register index width
`define CORE_REG_AW 5

// Architectural register count, x0 included
`define CORE_NUM_REGS 32

////////////////////////////////////////
// Boot
////////////////////////////////////////

// First address fetched after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

/* design/rv_isa_pkg.sv */
// RV32I base encodings only; compressed, CSR and system opcodes are not represented
package rv_isa_pkg;

    // One data word
    typedef logic [31:0] word_t;

    // Register index
    typedef logic [4:0] reg_idx_t;

    // Major opcode field
    typedef logic [6:0] opcode_t;

    // Major opcodes handled by decode
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // Execute operations
    // OP_NOP is zero so a cleared decode register is harmless
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_JAL,
        OP_JALR
    } exec_op_e;

endpackage

/* design/core_pipe_pkg.sv */
// Stage-to-stage bundles of the three-stage core; word accesses only on the memory side
package core_pipe_pkg;

    import rv_isa_pkg::*;

    // Decode to execute register
    typedef struct packed {
        logic     valid;
        exec_op_e op;
        reg_idx_t rd;
        // rs1 or pc
        word_t    first_operand;
        // rs2 or immediate
        word_t    second_operand;
        // Store data for SW, target for branches and JAL
        word_t    third_operand;
        word_t    pc;
    } dec_exec_t;

    // Register bank write port
    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    // Fetch redirection from execute
    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // Data memory request
    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

/* design/fetch.sv */
// Instruction memory must return the word for an address one cycle later and hold it during stall
`timescale 1ns/1ns
`include "core_defines.svh"

module fetch
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      stall_i,
    input  redirect_t redirect_i,
    output word_t     instruction_address_o,
    output word_t     pc_o
);

    // Address presented this cycle
    word_t pc_q;

    // Address presented last cycle
    // Its instruction is on the bus now
    word_t issued_q;

    word_t pc_next;

    ////////////////////////////////////////
    // Next address
    ////////////////////////////////////////

    // Redirect wins over sequential fetch
    always_comb begin
        if (redirect_i.taken) begin
            pc_next = redirect_i.target;
        end
        else begin
            pc_next = pc_q + word_t'(4);
        end
    end

    // Both registers freeze under stall
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q     <= `CORE_RESET_PC;
            issued_q <= `CORE_RESET_PC;
        end
        else if (!stall_i) begin
            pc_q     <= pc_next;
            issued_q <= pc_q;
        end
    end

    assign instruction_address_o = pc_q;
    assign pc_o                  = issued_q;

endmodule

/* design/decode.sv */
// Illegal or unsupported encodings decode to OP_NOP; one stale fetch is squashed after a redirect
`timescale 1ns/1ns
`include "core_defines.svh"

module decode
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      stall_i,
    input  word_t     instruction_i,
    input  word_t     pc_i,
    input  redirect_t redirect_i,
    output reg_idx_t  rs1_o,
    output reg_idx_t  rs2_o,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output dec_exec_t exec_o
);

    // Instruction fields
    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // Immediates per format
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // Decoded controls
    exec_op_e op;
    word_t    imm;
    logic     use_imm;
    logic     first_is_pc;

    dec_exec_t exec_d;
    dec_exec_t exec_q;

    // Instruction on the bus came from a stale address
    logic squash_q;

    // Register-register and register-immediate ALU ops share funct3
    function automatic exec_op_e alu_op(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  alu_op = alt ? OP_SUB : OP_ADD;
            3'b001:  alu_op = OP_SLL;
            3'b010:  alu_op = OP_SLT;
            3'b011:  alu_op = OP_SLTU;
            3'b100:  alu_op = OP_XOR;
            3'b101:  alu_op = alt ? OP_SRA : OP_SRL;
            3'b110:  alu_op = OP_OR;
            default: alu_op = OP_AND;
        endcase
    endfunction

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];

    // Register reads go straight to the bank
    assign rs1_o = instruction_i[15 +: `CORE_REG_AW];
    assign rs2_o = instruction_i[20 +: `CORE_REG_AW];

    ////////////////////////////////////////
    // Immediates
    ////////////////////////////////////////

    assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
    assign imm_s = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_b = {{19{instruction_i[31]}}, instruction_i[31], instruction_i[7],
                    instruction_i[30:25], instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'b0};
    assign imm_j = {{11{instruction_i[31]}}, instruction_i[31], instruction_i[19:12],
                    instruction_i[20], instruction_i[30:21], 1'b0};

    ////////////////////////////////////////
    // Operation decode
    ////////////////////////////////////////

    always_comb begin
        // I-type with rs1 is the common case
        op          = OP_NOP;
        imm         = imm_i;
        use_imm     = 1'b1;
        first_is_pc = 1'b0;
        case (opcode)
            OPC_LUI: begin
                op  = OP_LUI;
                imm = imm_u;
            end
            OPC_JAL: begin
                op          = OP_JAL;
                imm         = imm_j;
                first_is_pc = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    op = OP_JALR;
                end
            end
            OPC_BRANCH: begin
                // Compare rs1 with rs2
                imm     = imm_b;
                use_imm = 1'b0;
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    default: op = OP_NOP;
                endcase
            end
            OPC_LOAD: begin
                // Word loads only
                if (funct3 == 3'b010) begin
                    op = OP_LW;
                end
            end
            OPC_STORE: begin
                imm = imm_s;
                if (funct3 == 3'b010) begin
                    op = OP_SW;
                end
            end
            OPC_OPIMM: begin
                // Only SRAI reads the funct7 bit
                op = alu_op(funct3, funct3 == 3'b101 && funct7[5]);
            end
            OPC_OP: begin
                use_imm = 1'b0;
                if (funct7 == 7'b0000000) begin
                    op = alu_op(funct3, 1'b0);
                end
                else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
                    op = alu_op(funct3, 1'b1);
                end
            end
            default: begin
                op = OP_NOP;
            end
        endcase
    end

    ////////////////////////////////////////
    // Operands and pipeline register
    ////////////////////////////////////////

    always_comb begin
        // Killed by a redirect now or by the one taken last cycle
        exec_d.valid          = !redirect_i.taken && !squash_q;
        exec_d.op             = op;
        exec_d.rd             = instruction_i[7 +: `CORE_REG_AW];
        exec_d.first_operand  = first_is_pc ? pc_i : rs1_data_i;
        exec_d.second_operand = use_imm ? imm : rs2_data_i;
        // Store data or branch target
        exec_d.third_operand  = (op == OP_SW) ? rs2_data_i : pc_i + imm;
        exec_d.pc             = pc_i;
    end

    // Squash flag starts set, the bus carries nothing useful right after reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exec_q   <= '0;
            squash_q <= 1'b1;
        end
        else if (!stall_i) begin
            exec_q   <= exec_d;
            squash_q <= redirect_i.taken;
        end
    end

    assign exec_o = exec_q;

endmodule

/* design/regbank.sv */
// Flop register bank with x0 tied to zero; writes land at the edge and are forwarded in the same cycle
`timescale 1ns/1ns
`include "core_defines.svh"

module regbank
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     stall_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  wb_t      wb_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o
);

    // x1 to x31 only since x0 has no storage
    word_t regs [1:`CORE_NUM_REGS-1];

    // Write to x0 never counts
    logic write_en;

    // One read port with bypass
    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) begin
            read_port = '0;
        end
        else if (write_en && wb_i.rd == idx) begin
            read_port = wb_i.data;
        end
        else begin
            read_port = regs[idx];
        end
    endfunction

    assign write_en = wb_i.we && wb_i.rd != '0;

    // Writes wait out a stall
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end
        else if (write_en && !stall_i) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Reads follow the bank contents and the write port
    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

/* design/execute.sv */
// Single-cycle execute and retire; data memory must answer loads combinationally
`timescale 1ns/1ns
`include "core_defines.svh"

module execute
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  dec_exec_t exec_i,
    input  word_t     mem_data_i,
    output wb_t       wb_o,
    output redirect_t redirect_o,
    output mem_req_t  mem_req_o
);

    word_t op_a;
    word_t op_b;

    // Adder shared by ADD, address and JALR target
    word_t sum;
    word_t alu_result;
    word_t link;

    logic [$clog2(`CORE_XLEN)-1:0] shamt;

    logic branch_taken;
    logic writes_rd;

    assign op_a  = exec_i.first_operand;
    assign op_b  = exec_i.second_operand;
    assign sum   = op_a + op_b;
    assign shamt = op_b[$clog2(`CORE_XLEN)-1:0];
    assign link  = exec_i.pc + word_t'(4);

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (exec_i.op)
            OP_SUB:  alu_result = op_a - op_b;
            OP_AND:  alu_result = op_a & op_b;
            OP_OR:   alu_result = op_a | op_b;
            OP_XOR:  alu_result = op_a ^ op_b;
            OP_SLL:  alu_result = op_a << shamt;
            OP_SRL:  alu_result = op_a >> shamt;
            OP_SRA:  alu_result = word_t'($signed(op_a) >>> shamt);
            OP_SLT:  alu_result = word_t'($signed(op_a) < $signed(op_b));
            OP_SLTU: alu_result = word_t'(op_a < op_b);
            // Immediate already shifted in decode
            OP_LUI:  alu_result = op_b;
            default: alu_result = sum;
        endcase
    end

    ////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////

    always_comb begin
        case (exec_i.op)
            OP_BEQ:  branch_taken = op_a == op_b;
            OP_BNE:  branch_taken = op_a != op_b;
            OP_BLT:  branch_taken = $signed(op_a) < $signed(op_b);
            OP_BGE:  branch_taken = $signed(op_a) >= $signed(op_b);
            OP_JAL:  branch_taken = 1'b1;
            OP_JALR: branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    // JALR drops bit 0 of its target
    assign redirect_o.taken  = exec_i.valid && branch_taken;
    assign redirect_o.target = (exec_i.op == OP_JALR) ? {sum[31:1], 1'b0}
                                                      : exec_i.third_operand;

    ////////////////////////////////////////
    // Write-back and memory
    ////////////////////////////////////////

    // No register write for nop, stores and branches
    always_comb begin
        case (exec_i.op)
            OP_NOP, OP_SW, OP_BEQ, OP_BNE, OP_BLT, OP_BGE: writes_rd = 1'b0;
            default: writes_rd = 1'b1;
        endcase
    end

    always_comb begin
        wb_o.we = exec_i.valid && writes_rd;
        wb_o.rd = exec_i.rd;
        case (exec_i.op)
            OP_LW:          wb_o.data = mem_data_i;
            OP_JAL, OP_JALR: wb_o.data = link;
            default:        wb_o.data = alu_result;
        endcase
    end

    // Request held as long as the decode register holds
    assign mem_req_o.read  = exec_i.valid && exec_i.op == OP_LW;
    assign mem_req_o.write = exec_i.valid && exec_i.op == OP_SW;
    assign mem_req_o.addr  = sum;
    assign mem_req_o.wdata = exec_i.third_operand;

endmodule

/* design/rs5_core.sv */
// Three-stage RV32I core without CSRs or traps; word memory accesses only, stall_i freezes everything
`timescale 1ns/1ns
`include "core_defines.svh"

module rs5_core
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       stall_i,
    input  word_t      instruction_i,
    input  word_t      mem_data_i,
    output word_t      instruction_address_o,
    output logic       mem_operation_enable_o,
    output logic [3:0] mem_write_enable_o,
    output word_t      mem_address_o,
    output word_t      mem_data_o
);

    ////////////////////////////////////////
    // Stage wiring
    ////////////////////////////////////////

    // Address of the instruction arriving at decode
    word_t     pc_decode;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    dec_exec_t exec;
    wb_t       wb;
    redirect_t redirect;
    mem_req_t  mem_req;

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////

    fetch fetch1 (
        .clk                   (clk),
        .arst_n_i              (arst_n_i),
        .stall_i               (stall_i),
        .redirect_i            (redirect),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_decode)
    );

    ////////////////////////////////////////
    // Decode and register bank
    ////////////////////////////////////////

    decode decoder1 (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .pc_i          (pc_decode),
        .redirect_i    (redirect),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .exec_o        (exec)
    );

    regbank regbankff (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    ////////////////////////////////////////
    // Execute and retire
    ////////////////////////////////////////

    execute execute1 (
        .exec_i     (exec),
        .mem_data_i (mem_data_i),
        .wb_o       (wb),
        .redirect_o (redirect),
        .mem_req_o  (mem_req)
    );

    // Word stores enable all four bytes
    assign mem_operation_enable_o = mem_req.read || mem_req.write;
    assign mem_write_enable_o     = {4{mem_req.write}};
    assign mem_address_o          = mem_req.addr;
    assign mem_data_o             = mem_req.wdata;

endmodule

/* verif/tb_memory.sv */
// Word-only memory model of 256 instruction and 256 data words; upper address bits are ignored
`timescale 1ns/1ns

module tb_memory
    import rv_isa_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       stall_i,
    input  word_t      instruction_address_i,
    output word_t      instruction_o,
    input  logic       mem_operation_enable_i,
    input  logic [3:0] mem_write_enable_i,
    input  word_t      mem_address_i,
    input  word_t      mem_data_i,
    output word_t      mem_data_o
);

    localparam int depth = 256;

    // Program image loaded by the testbench before reset release
    word_t imem [depth];
    word_t dmem [depth];

    // Count of stores that reached the array
    int    store_count;

    // Background data derived from each word address
    initial begin
        store_count = 0;
        for (int i = 0; i < depth; i++) begin
            dmem[i] = 32'hd000_0000 | word_t'(i << 2);
        end
    end

    ////////////////////////////////////////
    // Instruction side
    ////////////////////////////////////////

    // One cycle read latency and word held while stalled
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instruction_o <= '0;
        end
        else if (!stall_i) begin
            instruction_o <= imem[instruction_address_i[9:2]];
        end
    end

    ////////////////////////////////////////
    // Data side
    ////////////////////////////////////////

    // Combinational read
    assign mem_data_o = dmem[mem_address_i[9:2]];

    // Store completes on the first unstalled edge
    always @(posedge clk) begin
        if (arst_n_i && !stall_i && mem_operation_enable_i && mem_write_enable_i == 4'hf) begin
            dmem[mem_address_i[9:2]] <= mem_data_i;
            store_count <= store_count + 1;
        end
    end

endmodule

/* verif/tb_rs5_core.sv */
// Program lives below 1 KiB and stores use x0-relative addresses from 0x200; ends in a self-loop
`timescale 1ns/1ns
`include "core_defines.svh"

module tb_rs5_core
    import rv_isa_pkg::*;
;

    localparam word_t poison_word = 32'hdead_beef;
    localparam word_t poison_addr = 32'h0000_01f0;

    logic       clk;
    logic       arst_n_i;
    logic       stall_i;
    word_t      instruction;
    word_t      mem_rdata;
    word_t      instruction_address;
    logic       mem_en;
    logic [3:0] mem_we;
    word_t      mem_addr;
    word_t      mem_wdata;

    // Generated program and ISA model state
    word_t prog [$];
    word_t model_x [32];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t next_addr;

    int errors;
    int checks;
    int store_idx;
    int stall_cnt;
    int cycle_cnt;
    int since_reset;

    // Values at the previous negedge for the stall check
    logic  prev_valid;
    logic  prev_stall;
    word_t prev_iaddr;
    logic  prev_en;
    logic [3:0] prev_we;
    word_t prev_addr;
    word_t prev_wdata;

    rs5_core rs5_core_i (
        .clk                    (clk),
        .arst_n_i               (arst_n_i),
        .stall_i                (stall_i),
        .instruction_i          (instruction),
        .mem_data_i             (mem_rdata),
        .instruction_address_o  (instruction_address),
        .mem_operation_enable_o (mem_en),
        .mem_write_enable_o     (mem_we),
        .mem_address_o          (mem_addr),
        .mem_data_o             (mem_wdata)
    );

    tb_memory mem_i (
        .clk                    (clk),
        .arst_n_i               (arst_n_i),
        .stall_i                (stall_i),
        .instruction_address_i  (instruction_address),
        .instruction_o          (instruction),
        .mem_operation_enable_i (mem_en),
        .mem_write_enable_i     (mem_we),
        .mem_address_i          (mem_addr),
        .mem_data_i             (mem_wdata),
        .mem_data_o             (mem_rdata)
    );

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////

    function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        enc_r = {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic word_t enc_i(word_t imm, int rs1, logic [2:0] f3, int rd, logic [6:0] opc);
        enc_i = {imm[11:0], 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic word_t enc_s(word_t imm, int rs2);
        enc_s = {imm[11:5], 5'(rs2), 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(word_t imm, int rs2, int rs1, logic [2:0] f3);
        enc_b = {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(word_t imm, int rd);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
    endfunction

    ////////////////////////////////////////
    // Scalar ISA model
    ////////////////////////////////////////

    // Selector order add sub sll slt sltu xor srl sra or and
    function automatic word_t alu_model(int sel, word_t a, word_t b);
        case (sel)
            0: alu_model = a + b;
            1: alu_model = a - b;
            2: alu_model = a << b[4:0];
            3: alu_model = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4: alu_model = (a < b) ? 32'd1 : 32'd0;
            5: alu_model = a ^ b;
            6: alu_model = a >> b[4:0];
            7: alu_model = word_t'($signed(a) >>> b[4:0]);
            8: alu_model = a | b;
            default: alu_model = a & b;
        endcase
    endfunction

    function automatic logic [2:0] alu_funct3(int sel);
        logic [2:0] table_f3 [10];
        table_f3 = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        alu_funct3 = table_f3[sel];
    endfunction

    // Branch kinds 0 beq, 1 bne, 2 blt, 3 bge
    function automatic logic branch_model(int kind, word_t a, word_t b);
        case (kind)
            0: branch_model = a == b;
            1: branch_model = a != b;
            2: branch_model = $signed(a) < $signed(b);
            default: branch_model = $signed(a) >= $signed(b);
        endcase
    endfunction

    ////////////////////////////////////////
    // Program builder
    ////////////////////////////////////////

    task automatic emit(word_t w);
        prog.push_back(w);
    endtask

    // LUI plus ADDI with the upper part rounded for the signed low part
    task automatic load_const(int rd, word_t c);
        word_t hi;
        hi = (c + 32'h800) >> 12;
        emit({hi[19:0], 5'(rd), 7'b0110111});
        emit(enc_i(c, rd, 3'b000, rd, 7'b0010011));
        model_x[rd] = c;
    endtask

    task automatic store_reg(int rs);
        emit(enc_s(next_addr, rs));
        exp_addr.push_back(next_addr);
        exp_data.push_back(model_x[rs]);
        next_addr += 4;
    endtask

    // Two shadow slots holding poison when taken or one expected store otherwise
    task automatic shadow_slots(logic taken);
        if (taken) begin
            emit(enc_s(poison_addr, 8));
            emit(enc_s(poison_addr, 8));
        end
        else begin
            store_reg(9);
            emit(enc_i(32'd0, 0, 3'b000, 0, 7'b0010011));
        end
    endtask

    task automatic build_program();
        word_t a;
        word_t b;
        word_t pc;
        word_t lo;
        logic  taken;
        for (int r = 0; r < 32; r++) begin
            model_x[r] = '0;
        end
        next_addr = 32'h200;
        load_const(8, poison_word);
        load_const(9, $urandom());
        // Each ALU op twice with the result consumed the very next cycle
        for (int sel = 0; sel < 10; sel++) begin
            load_const(1, $urandom());
            load_const(2, $urandom());
            emit(enc_r((sel == 1 || sel == 7) ? 7'h20 : 7'h00, 2, 1, alu_funct3(sel), 3));
            model_x[3] = alu_model(sel, model_x[1], model_x[2]);
            store_reg(3);
            emit(enc_r((sel == 1 || sel == 7) ? 7'h20 : 7'h00, 1, 3, alu_funct3(sel), 4));
            model_x[4] = alu_model(sel, model_x[3], model_x[1]);
            store_reg(4);
        end
        // Bare LUI
        a = $urandom();
        emit({a[31:12], 5'd3, 7'b0110111});
        model_x[3] = {a[31:12], 12'h000};
        store_reg(3);
        // Reload earlier results through the data memory
        for (int k = 0; k < 3; k++) begin
            emit(enc_i(exp_addr[k], 0, 3'b010, 5, 7'b0000011));
            model_x[5] = exp_data[k];
            store_reg(5);
        end
        // x0 stays zero
        emit(enc_r(7'h00, 2, 1, 3'b000, 0));
        store_reg(0);
        // Every branch kind, taken and not taken
        for (int kind = 0; kind < 4; kind++) begin
            for (int want = 0; want < 2; want++) begin
                a = $urandom();
                if (kind == 0) begin
                    b = (want == 0) ? a : a ^ 32'd1;
                end
                else if (kind == 1) begin
                    b = (want == 0) ? a ^ 32'd1 : a;
                end
                else begin
                    // Opposite signs so signed and unsigned orders differ
                    b = a ^ 32'h8000_0000;
                    if (want == 1) begin
                        lo = a;
                        a  = b;
                        b  = lo;
                    end
                end
                load_const(6, a);
                load_const(7, b);
                taken = branch_model(kind, a, b);
                emit(enc_b(32'd12, 7, 6, (kind < 2) ? 3'(kind) : 3'(kind + 2)));
                shadow_slots(taken);
            end
        end
        // JAL over two poison slots
        pc = word_t'(prog.size() * 4);
        emit(enc_j(32'd12, 10));
        model_x[10] = pc + 4;
        shadow_slots(1'b1);
        store_reg(10);
        // JALR with bit 0 set in the base
        pc = word_t'((prog.size() + 2) * 4);
        load_const(11, (pc + 12) | 32'd1);
        emit(enc_i(32'd0, 11, 3'b000, 12, 7'b1100111));
        model_x[12] = pc + 4;
        shadow_slots(1'b1);
        store_reg(12);
        // Park on a self-loop
        emit(enc_j(32'd0, 0));
    endtask

    ////////////////////////////////////////
    // Clock, reset, stall
    ////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (arst_n_i) begin
            if (stall_i) begin
                stall_cnt++;
            end
            stall_i <= ($urandom_range(0, 5) == 0);
        end
    end

    ////////////////////////////////////////
    // Checks at the falling edge
    ////////////////////////////////////////

    // One named output against its expected value
    task automatic compare_value(string name, word_t expected, word_t actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    always @(negedge clk) begin
        // Reset state and the first cycle after release
        if (!arst_n_i || since_reset == 0) begin
            compare_value("instruction_address_o", `CORE_RESET_PC, instruction_address);
            compare_value("mem_operation_enable_o", 32'd0, word_t'(mem_en));
        end
        if (!arst_n_i) begin
            since_reset = 0;
        end
        else begin
            since_reset++;
        end
        // Outputs frozen across a stalled edge
        if (arst_n_i && prev_valid && prev_stall) begin
            compare_value("instruction_address_o", prev_iaddr, instruction_address);
            compare_value("mem_operation_enable_o", word_t'(prev_en), word_t'(mem_en));
            compare_value("mem_write_enable_o", word_t'(prev_we), word_t'(mem_we));
            compare_value("mem_address_o", prev_addr, mem_addr);
            compare_value("mem_data_o", prev_wdata, mem_wdata);
        end
        prev_valid = arst_n_i;
        prev_stall = stall_i;
        prev_iaddr = instruction_address;
        prev_en    = mem_en;
        prev_we    = mem_we;
        prev_addr  = mem_addr;
        prev_wdata = mem_wdata;
        // A store commits at the next edge
        if (arst_n_i && !stall_i && mem_en && mem_we == 4'hf) begin
            checks++;
            assert (mem_wdata != poison_word) else begin
                errors++;
                $display("Store from a squashed instruction reached memory at %0t", $time);
            end
            if (mem_wdata != poison_word) begin
                assert (store_idx < exp_addr.size()) else begin
                    errors++;
                    $display("More stores reached memory than the program issues at %0t", $time);
                end
                if (store_idx < exp_addr.size()) begin
                    compare_value("mem_address_o", exp_addr[store_idx], mem_addr);
                    compare_value("mem_data_o", exp_data[store_idx], mem_wdata);
                    store_idx++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    initial begin
        @(posedge arst_n_i);
        while (cycle_cnt <= prog.size() * 3 + stall_cnt + 50) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the program did not complete its stores in time (%0d of %0d)",
                 store_idx, exp_addr.size());
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Test failures found");
        $finish;
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'h5c7df589));
        arst_n_i    = 1'b0;
        stall_i     = 1'b0;
        errors      = 0;
        checks      = 0;
        store_idx   = 0;
        stall_cnt   = 0;
        cycle_cnt   = 0;
        since_reset = 0;
        prev_valid  = 1'b0;
        build_program();
        // Unused words decode as harmless ADDI x0 tagged with their index
        for (int i = 0; i < 256; i++) begin
            mem_i.imem[i] = (i < prog.size()) ? prog[i] : enc_i(word_t'(i), 0, 3'b000, 0, 7'h13);
        end
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
        wait (store_idx == exp_addr.size());
        // Drain to catch stray stores
        repeat (20) @(posedge clk);
        checks++;
        assert (mem_i.store_count == exp_addr.size()) else begin
            errors++;
            $display("[ERROR] %0t store_count expected %0d actual %0d",
                     $time, exp_addr.size(), mem_i.store_count);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end
        else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
design/rv_isa_pkg.sv
design/core_pipe_pkg.sv
design/fetch.sv
design/decode.sv
design/regbank.sv
design/execute.sv
design/rs5_core.sv
verif/tb_memory.sv
verif/tb_rs5_core.sv

/* Bender.yml */
package:
  name: rs5_core

export_include_dirs:
  - include

sources:
  - files:
      - design/rv_isa_pkg.sv
      - design/core_pipe_pkg.sv
      - design/fetch.sv
      - design/decode.sv
      - design/regbank.sv
      - design/execute.sv
      - design/rs5_core.sv
  - target: simulation
    files:
      - verif/tb_memory.sv
      - verif/tb_rs5_core.sv
